//--- adc_panel_settings.svh
//////////////////////////////
// board panel build settings
// include where a macro is needed
//////////////////////////////
`ifndef ADC_PANEL_SETTINGS_SVH
`define ADC_PANEL_SETTINGS_SVH

// 7-bit address of the converter on the bus
`define ADC_DEV_ADDR 7'h48

// control byte selecting the converter input
`define ADC_CHANNEL 8'h01

// system clocks per quarter scl period
`define SCL_DIV 8

// idle clocks between stop and next start
`define POLL_GAP 200

// clocks a key level has to hold
`define DEBOUNCE_CYCLES 20

`define KEY_COUNT 2

// clocks per selected display digit
`define SCAN_CYCLES 50

`endif

//--- i2c_pkg.sv
//////////////////////////////
// types of the i2c converter reader
//////////////////////////////
package i2c_pkg;

	// reader FSM
	typedef enum logic [3:0] {
		st_idle,
		st_start,
		// master drives one byte
		st_shift,
		// slave ack bit
		st_ack,
		st_restart,
		// slave drives one byte
		st_read,
		st_mnack,
		st_stop,
		// wait between transactions
		st_gap
	} i2c_state_t;

	// which byte goes out in st_shift
	typedef enum logic [1:0] {
		ph_addr_wr,
		ph_ctrl,
		ph_addr_rd
	} i2c_phase_t;

endpackage

//--- panel_pkg.sv
//////////////////////////////
// types of the display side
//////////////////////////////
package panel_pkg;

	typedef enum logic {
		mode_dec,
		mode_hex
	} disp_mode_t;

	// 0 to 15 are the hex digits, the rest are special glyphs
	typedef enum logic [4:0] {
		glyph_0 = 5'd0,
		glyph_1 = 5'd1,
		glyph_2 = 5'd2,
		glyph_3 = 5'd3,
		glyph_4 = 5'd4,
		glyph_5 = 5'd5,
		glyph_6 = 5'd6,
		glyph_7 = 5'd7,
		glyph_8 = 5'd8,
		glyph_9 = 5'd9,
		glyph_a = 5'd10,
		glyph_b = 5'd11,
		glyph_c = 5'd12,
		glyph_d = 5'd13,
		glyph_e = 5'd14,
		glyph_f = 5'd15,
		glyph_blank = 5'd16,
		glyph_let_d = 5'd17,
		glyph_let_h = 5'd18
	} glyph_t;

endpackage

//--- i2c_adc_reader.sv
//////////////////////////////
// i2c master polling one converter sample
// write control byte, repeated start, read one byte
// new sample flagged by a one-cycle strobe
//////////////////////////////
`include "adc_panel_settings.svh"

module i2c_adc_reader (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	output logic       scl,
	inout  wire        sda,
	output logic [7:0] sample,
	output logic       sample_vld,
	output logic       ack_error
);
	import i2c_pkg::*;

	localparam int TICK_W = $clog2(`SCL_DIV + 1);
	localparam int GAP_W = $clog2(`POLL_GAP + 1);

	logic [TICK_W-1:0] tick_cnt;
	logic              tick;
	logic              sample_pt;
	logic              bit_end;
	i2c_state_t        state;
	i2c_phase_t        phase;
	logic [1:0]        quarter;
	logic [2:0]        bit_cnt;
	logic [GAP_W-1:0]  gap_cnt;
	logic              nacked;
	logic [7:0]        tx_sr;
	logic [7:0]        rx_sr;
	logic [1:0]        sda_sync;
	logic              sda_in;
	logic              scl_next;
	logic              sda_next;
	logic              scl_r;
	logic              sda_r;
	logic              bus_cond;

	// quarter period tick
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tick_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	assign tick = (tick_cnt == TICK_W'(`SCL_DIV - 1));
	// sample in the middle of scl high, move on at the end of the bit
	assign sample_pt = tick && (quarter == 2'd2);
	assign bit_end = tick && (quarter == 2'd3) && !(state inside {st_idle, st_gap});

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sda_sync <= 2'b11;
		end else begin
			sda_sync <= {sda_sync[0], sda};
		end
	end

	assign sda_in = sda_sync[1];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= st_gap;
			phase <= ph_addr_wr;
			quarter <= 2'd0;
			bit_cnt <= 3'd0;
			gap_cnt <= '0;
			nacked <= 1'b0;
			sample_vld <= 1'b0;
			ack_error <= 1'b0;
		end else begin
			sample_vld <= 1'b0;
			ack_error <= 1'b0;
			case (state)
				st_gap: begin
					if (gap_cnt == GAP_W'(`POLL_GAP - 1)) begin
						gap_cnt <= '0;
						state <= st_idle;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				// line up the start with the tick
				st_idle: begin
					if (tick) begin
						state <= st_start;
						quarter <= 2'd0;
						nacked <= 1'b0;
					end
				end
				default: begin
					if (tick) begin
						quarter <= quarter + 1'b1;
					end
					if (sample_pt && state == st_ack) begin
						nacked <= sda_in;
					end
					if (bit_end) begin
						case (state)
							st_start: begin
								state <= st_shift;
								phase <= ph_addr_wr;
								bit_cnt <= 3'd0;
							end
							st_shift: begin
								bit_cnt <= bit_cnt + 1'b1;
								if (bit_cnt == 3'd7) begin
									state <= st_ack;
								end
							end
							st_ack: begin
								if (nacked) begin
									state <= st_stop;
								end else begin
									case (phase)
										ph_addr_wr: begin
											phase <= ph_ctrl;
											state <= st_shift;
										end
										ph_ctrl: state <= st_restart;
										default: state <= st_read;
									endcase
								end
							end
							st_restart: begin
								state <= st_shift;
								phase <= ph_addr_rd;
								bit_cnt <= 3'd0;
							end
							st_read: begin
								bit_cnt <= bit_cnt + 1'b1;
								if (bit_cnt == 3'd7) begin
									state <= st_mnack;
								end
							end
							st_mnack: state <= st_stop;
							st_stop: begin
								state <= st_gap;
								ack_error <= nacked;
								sample_vld <= !nacked;
							end
							default: state <= st_idle;
						endcase
					end
				end
			endcase
		end
	end

	// shift registers and sample
	always_ff @(posedge sys_clk) begin
		if (sample_pt && state == st_read) begin
			rx_sr <= {rx_sr[6:0], sda_in};
		end
		if (bit_end) begin
			case (state)
				st_start: tx_sr <= {`ADC_DEV_ADDR, 1'b0};
				st_restart: tx_sr <= {`ADC_DEV_ADDR, 1'b1};
				st_shift: tx_sr <= {tx_sr[6:0], 1'b1};
				st_ack: begin
					if (phase == ph_addr_wr) begin
						tx_sr <= `ADC_CHANNEL;
					end
				end
				st_stop: begin
					if (!nacked) begin
						sample <= rx_sr;
					end
				end
				default: ;
			endcase
		end
	end

	// bus levels per quarter, scl high in quarters 1 and 2 of a bit
	always_comb begin
		scl_next = 1'b1;
		sda_next = 1'b1;
		case (state)
			st_start: begin
				scl_next = (quarter != 2'd3);
				sda_next = (quarter < 2'd2);
			end
			st_restart: begin
				scl_next = (quarter == 2'd1) || (quarter == 2'd2);
				sda_next = (quarter < 2'd2);
			end
			st_stop: begin
				scl_next = (quarter != 2'd0);
				sda_next = (quarter >= 2'd2);
			end
			st_shift: begin
				scl_next = (quarter == 2'd1) || (quarter == 2'd2);
				sda_next = tx_sr[7];
			end
			st_ack, st_read, st_mnack: begin
				scl_next = (quarter == 2'd1) || (quarter == 2'd2);
			end
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scl_r <= 1'b1;
			sda_r <= 1'b1;
			bus_cond <= 1'b0;
		end else begin
			scl_r <= scl_next;
			sda_r <= sda_next;
			bus_cond <= state inside {st_start, st_restart, st_stop};
		end
	end

	assign scl = scl_r;
	// open drain, released means pulled up
	assign sda = sda_r ? 1'bz : 1'b0;

	a_sda_stable_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(scl_r && $past(scl_r) && !bus_cond && !$past(bus_cond)) |-> $stable(sda_r));

	a_vld_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		sample_vld |=> !sample_vld);

	// a nacked round keeps the old sample and gives no strobe
	a_nack_no_sample: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		ack_error |-> (!sample_vld && sample === $past(sample)));

endmodule

//--- key_debounce.sv
//////////////////////////////
// button synchroniser and debouncer
// one pulse per accepted press
//////////////////////////////
`include "adc_panel_settings.svh"

module key_debounce (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  logic [`KEY_COUNT-1:0] key_in,
	output logic [`KEY_COUNT-1:0] key_press
);
	localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

	logic [`KEY_COUNT-1:0] sync_a;
	logic [`KEY_COUNT-1:0] sync_b;
	logic [`KEY_COUNT-1:0] level;
	logic [`KEY_COUNT-1:0] level_d;
	logic [CNT_W-1:0]      stable_cnt [`KEY_COUNT];

	// buttons idle high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sync_a <= '1;
			sync_b <= '1;
		end else begin
			sync_a <= key_in;
			sync_b <= sync_a;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			level <= '1;
			for (int i = 0; i < `KEY_COUNT; i++) begin
				stable_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `KEY_COUNT; i++) begin
				if (sync_b[i] == level[i]) begin
					stable_cnt[i] <= '0;
				end else if (stable_cnt[i] == CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
					// new level held long enough
					level[i] <= sync_b[i];
					stable_cnt[i] <= '0;
				end else begin
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
				end
			end
		end
	end

	// falling accepted level is a press
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			level_d <= '1;
			key_press <= '0;
		end else begin
			level_d <= level;
			key_press <= level_d & ~level;
		end
	end

	a_press_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(key_press & $past(key_press)) == '0);

endmodule

//--- display_formatter.sv
//////////////////////////////
// sample, mode and hold to eight glyph codes
// digit 7 carries the mode letter
//////////////////////////////
`include "adc_panel_settings.svh"

module display_formatter (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  logic [7:0]            sample,
	input  logic                  sample_vld,
	input  logic [`KEY_COUNT-1:0] key_press,
	output logic [7:0]            led,
	output logic [39:0]           glyphs
);
	import panel_pkg::*;

	logic [7:0]  latest;
	logic        latest_vld;
	logic [7:0]  shown;
	logic        shown_vld;
	disp_mode_t  mode;
	logic        hold;
	logic [11:0] bcd;
	glyph_t      digit [8];

	// double dabble, hundreds never exceed 2
	function automatic logic [11:0] to_bcd(input logic [7:0] bin);
		logic [19:0] work;
		work = {12'd0, bin};
		for (int i = 0; i < 8; i++) begin
			if (work[11:8] > 4'd4) begin
				work[11:8] = work[11:8] + 4'd3;
			end
			if (work[15:12] > 4'd4) begin
				work[15:12] = work[15:12] + 4'd3;
			end
			work = work << 1;
		end
		return work[19:8];
	endfunction

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			latest <= 8'd0;
			latest_vld <= 1'b0;
			shown <= 8'd0;
			shown_vld <= 1'b0;
			mode <= mode_dec;
			hold <= 1'b0;
		end else begin
			if (sample_vld) begin
				latest <= sample;
				latest_vld <= 1'b1;
			end
			if (key_press[0]) begin
				mode <= (mode == mode_dec) ? mode_hex : mode_dec;
			end
			if (key_press[1]) begin
				hold <= !hold;
			end
			if (sample_vld && !hold) begin
				shown <= sample;
				shown_vld <= 1'b1;
			end else if (key_press[1] && hold) begin
				// leaving hold, catch up with the newest sample
				shown <= sample_vld ? sample : latest;
				shown_vld <= latest_vld | sample_vld;
			end
		end
	end

	assign led = latest;

	always_comb begin
		bcd = to_bcd(shown);
		for (int i = 0; i < 8; i++) begin
			digit[i] = glyph_blank;
		end
		if (mode == mode_dec) begin
			digit[7] = glyph_let_d;
			if (shown_vld) begin
				// units always shown, higher zeros blanked
				digit[0] = glyph_t'({1'b0, bcd[3:0]});
				if (bcd[11:4] != 8'd0) begin
					digit[1] = glyph_t'({1'b0, bcd[7:4]});
				end
				if (bcd[11:8] != 4'd0) begin
					digit[2] = glyph_t'({1'b0, bcd[11:8]});
				end
			end
		end else begin
			digit[7] = glyph_let_h;
			if (shown_vld) begin
				digit[1] = glyph_t'({1'b0, shown[7:4]});
				digit[0] = glyph_t'({1'b0, shown[3:0]});
			end
		end
		for (int i = 0; i < 8; i++) begin
			glyphs[5*i +: 5] = digit[i];
		end
	end

endmodule

//--- seg_scan.sv
//////////////////////////////
// eight digit seven-segment scan driver
// active low segments and digit select
//////////////////////////////
`include "adc_panel_settings.svh"

module seg_scan (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic [39:0] glyphs,
	output logic [7:0]  seg_number,
	output logic [7:0]  seg_choice
);
	import panel_pkg::*;

	localparam int SCAN_W = $clog2(`SCAN_CYCLES + 1);

	logic [SCAN_W-1:0] scan_cnt;
	logic [2:0]        sel;
	glyph_t            cur_glyph;

	// bit order dp g f e d c b a, dp kept off
	function automatic logic [7:0] glyph_to_seg(input glyph_t g);
		case (g)
			glyph_0: return 8'hc0;
			glyph_1: return 8'hf9;
			glyph_2: return 8'ha4;
			glyph_3: return 8'hb0;
			glyph_4: return 8'h99;
			glyph_5: return 8'h92;
			glyph_6: return 8'h82;
			glyph_7: return 8'hf8;
			glyph_8: return 8'h80;
			glyph_9: return 8'h90;
			glyph_a: return 8'h88;
			glyph_b: return 8'h83;
			glyph_c: return 8'hc6;
			glyph_d: return 8'ha1;
			glyph_e: return 8'h86;
			glyph_f: return 8'h8e;
			glyph_let_d: return 8'ha1;
			glyph_let_h: return 8'h8b;
			default: return 8'hff;
		endcase
	endfunction

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scan_cnt <= '0;
			sel <= 3'd0;
		end else if (scan_cnt == SCAN_W'(`SCAN_CYCLES - 1)) begin
			scan_cnt <= '0;
			sel <= sel + 1'b1;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	assign cur_glyph = glyph_t'(glyphs[5*sel +: 5]);

	// segments and select registered together
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			seg_number <= 8'hff;
			seg_choice <= 8'hfe;
		end else begin
			seg_number <= glyph_to_seg(cur_glyph);
			seg_choice <= ~(8'd1 << sel);
		end
	end

	a_one_digit: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$onehot(~seg_choice));

endmodule

//--- adc_panel_top.sv
//////////////////////////////
// board panel top, converter reader plus
// buttons and seven-segment display
//////////////////////////////
`include "adc_panel_settings.svh"

module adc_panel_top (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  logic [`KEY_COUNT-1:0] key_in,
	output logic [7:0]            led,
	output logic [7:0]            seg_number,
	output logic [7:0]            seg_choice,
	output logic                  scl,
	inout  wire                   sda
);

	logic [7:0]            sample;
	logic                  sample_vld;
	logic [`KEY_COUNT-1:0] key_press;
	logic [39:0]           glyphs;

	// ack_error only feeds the reader's own checks here
	i2c_adc_reader u_i2c_adc_reader (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.scl        (scl),
		.sda        (sda),
		.sample     (sample),
		.sample_vld (sample_vld),
		.ack_error  ()
	);

	key_debounce u_key_debounce (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key_in    (key_in),
		.key_press (key_press)
	);

	display_formatter u_display_formatter (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.sample     (sample),
		.sample_vld (sample_vld),
		.key_press  (key_press),
		.led        (led),
		.glyphs     (glyphs)
	);

	seg_scan u_seg_scan (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.glyphs     (glyphs),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

endmodule

//--- tb_i2c_adc_model.sv
//////////////////////////////
// converter slave model on the i2c bus
// checks the request bytes, answers from a queue
//////////////////////////////
`include "adc_panel_settings.svh"

module tb_i2c_adc_model (
	input  logic       sys_clk,
	input  logic       scl,
	inout  wire        sda,
	input  logic [7:0] push_value,
	input  logic       push_valid,
	output int         start_cnt,
	output int         served_cnt,
	output int         byte_errors
);
	logic [7:0] value_q [$];
	logic [7:0] last_value;
	logic [7:0] rx_byte;
	logic [7:0] tx_byte;
	logic       scl_q;
	logic       sda_q;
	logic       drive_low;
	logic       in_txn;
	logic       reading;
	logic       ack_phase;
	logic       from_queue;
	int         bit_idx;
	int         byte_idx;
	int         starts;
	int         served;
	int         errors;

	assign sda = drive_low ? 1'b0 : 1'bz;
	assign start_cnt = starts;
	assign served_cnt = served;
	assign byte_errors = errors;

	// byte order: address-write, control, address-read
	function automatic logic [7:0] expected_byte(input int idx);
		case (idx)
			0: return {`ADC_DEV_ADDR, 1'b0};
			1: return `ADC_CHANNEL;
			default: return {`ADC_DEV_ADDR, 1'b1};
		endcase
	endfunction

	initial begin
		last_value = 8'h00;
		rx_byte = 8'h00;
		tx_byte = 8'h00;
		scl_q = 1'b1;
		sda_q = 1'b1;
		drive_low = 1'b0;
		in_txn = 1'b0;
		reading = 1'b0;
		ack_phase = 1'b0;
		from_queue = 1'b0;
		bit_idx = 0;
		byte_idx = 0;
		starts = 0;
		served = 0;
		errors = 0;
	end

	always @(posedge sys_clk) begin
		if (push_valid) begin
			value_q.push_back(push_value);
		end
	end

	task automatic on_scl_rise();
		if (reading) begin
			bit_idx++;
			// ninth bit is the master nack
			if (bit_idx == 9 && sda !== 1'b1) begin
				$display("master acknowledged the data byte instead of a nack");
				errors++;
			end
		end else if (!ack_phase && byte_idx < 3 && bit_idx < 8) begin
			rx_byte = {rx_byte[6:0], (sda === 1'b1)};
			bit_idx++;
			if (bit_idx == 8 && rx_byte !== expected_byte(byte_idx)) begin
				$display("mismatch i2c byte %0d: got 0x%02h expected 0x%02h",
					byte_idx, rx_byte, expected_byte(byte_idx));
				errors++;
			end
		end
	endtask

	task automatic on_scl_fall();
		if (ack_phase) begin
			ack_phase = 1'b0;
			drive_low = 1'b0;
			byte_idx++;
			bit_idx = 0;
			if (byte_idx == 3) begin
				reading = 1'b1;
				// repeat the last value once the queue runs dry
				from_queue = (value_q.size() > 0);
				if (from_queue) begin
					tx_byte = value_q.pop_front();
				end else begin
					tx_byte = last_value;
				end
				last_value = tx_byte;
				drive_low = !tx_byte[7];
			end
		end else if (reading) begin
			if (bit_idx < 8) begin
				drive_low = !tx_byte[7 - bit_idx];
			end else if (bit_idx == 8) begin
				drive_low = 1'b0;
			end else begin
				reading = 1'b0;
				byte_idx = 4;
			end
		end else if (bit_idx == 8 && byte_idx < 3) begin
			drive_low = 1'b1;
			ack_phase = 1'b1;
		end
	endtask

	always @(scl or sda) begin
		if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
			// start or repeated start
			if (in_txn && byte_idx != 2) begin
				$display("repeated start arrived after %0d bytes", byte_idx);
				errors++;
			end
			if (!in_txn) begin
				starts++;
				byte_idx = 0;
			end
			in_txn = 1'b1;
			reading = 1'b0;
			ack_phase = 1'b0;
			bit_idx = 0;
			drive_low = 1'b0;
		end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
			if (in_txn && byte_idx != 4) begin
				$display("transaction stopped after %0d bytes", byte_idx);
				errors++;
			end else if (in_txn && from_queue) begin
				served++;
			end
			in_txn = 1'b0;
			reading = 1'b0;
			drive_low = 1'b0;
		end else if (in_txn && scl_q === 1'b0 && scl === 1'b1) begin
			on_scl_rise();
		end else if (in_txn && scl_q === 1'b1 && scl === 1'b0) begin
			on_scl_fall();
		end
		scl_q = scl;
		sda_q = sda;
	end

endmodule

//--- tb_adc_panel.sv
//////////////////////////////
// testbench for the board panel
// converter model on the bus, table of samples and key actions
//////////////////////////////
`include "adc_panel_settings.svh"

module tb_adc_panel;
	import panel_pkg::*;

	localparam int ACT_NONE = 0;
	localparam int ACT_MODE = 1;
	localparam int ACT_HOLD = 2;
	localparam int ACT_GLITCH = 3;
	localparam int VAL_RANDOM = -1;
	localparam int VAL_NONE = -2;
	localparam int SAME = -1;
	localparam int WAIT_LIMIT = 10000;
	localparam int ROWS = 19;

	logic                  sys_clk;
	logic                  sys_rst_n;
	logic [`KEY_COUNT-1:0] key_in;
	wire  [7:0]            led;
	wire  [7:0]            seg_number;
	wire  [7:0]            seg_choice;
	wire                   scl;
	wire                   sda;
	logic [7:0]            push_value;
	logic                  push_valid;
	int                    start_cnt;
	int                    served_cnt;
	int                    model_errors;
	int                    mismatches;
	int                    timeouts;
	int                    seed;
	logic [7:0]            newest;
	logic [7:0]            got_seg [8];

	// key action, sample, expected mode (1 is hex), expected shown value
	int stim [ROWS][4] = '{
		'{ACT_NONE,   0,          0, SAME},
		'{ACT_NONE,   7,          0, SAME},
		'{ACT_NONE,   42,         0, SAME},
		'{ACT_NONE,   99,         0, SAME},
		'{ACT_NONE,   100,        0, SAME},
		'{ACT_NONE,   255,        0, SAME},
		'{ACT_NONE,   VAL_RANDOM, 0, SAME},
		'{ACT_NONE,   VAL_RANDOM, 0, SAME},
		'{ACT_MODE,   0,          1, SAME},
		'{ACT_NONE,   7,          1, SAME},
		'{ACT_NONE,   42,         1, SAME},
		'{ACT_NONE,   100,        1, SAME},
		'{ACT_NONE,   VAL_RANDOM, 1, SAME},
		'{ACT_MODE,   42,         0, SAME},
		// hold on, later samples stay hidden until release
		'{ACT_HOLD,   77,         0, 42},
		'{ACT_NONE,   200,        0, 42},
		'{ACT_HOLD,   VAL_NONE,   0, 200},
		'{ACT_GLITCH, 13,         0, SAME},
		'{ACT_NONE,   VAL_RANDOM, 0, SAME}
	};

	adc_panel_top u_adc_panel_top (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.key_in     (key_in),
		.led        (led),
		.seg_number (seg_number),
		.seg_choice (seg_choice),
		.scl        (scl),
		.sda        (sda)
	);

	tb_i2c_adc_model u_i2c_adc_model (
		.sys_clk     (sys_clk),
		.scl         (scl),
		.sda         (sda),
		.push_value  (push_value),
		.push_valid  (push_valid),
		.start_cnt   (start_cnt),
		.served_cnt  (served_cnt),
		.byte_errors (model_errors)
	);

	pullup (sda);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// active low a to g, dp off
	function automatic logic [7:0] seg_pattern(input logic [4:0] g);
		case (g)
			glyph_0: return 8'hc0;
			glyph_1: return 8'hf9;
			glyph_2: return 8'ha4;
			glyph_3: return 8'hb0;
			glyph_4: return 8'h99;
			glyph_5: return 8'h92;
			glyph_6: return 8'h82;
			glyph_7: return 8'hf8;
			glyph_8: return 8'h80;
			glyph_9: return 8'h90;
			glyph_a: return 8'h88;
			glyph_b: return 8'h83;
			glyph_c: return 8'hc6;
			glyph_d: return 8'ha1;
			glyph_e: return 8'h86;
			glyph_f: return 8'h8e;
			glyph_let_d: return 8'ha1;
			glyph_let_h: return 8'h8b;
			default: return 8'hff;
		endcase
	endfunction

	function automatic logic [39:0] expected_glyphs(input logic valid, input logic hex,
		input logic [7:0] v);
		logic [4:0]  g [8];
		logic [39:0] all_g;
		int          hundreds;
		int          tens;
		int          units;
		hundreds = v / 100;
		tens = (v / 10) % 10;
		units = v % 10;
		for (int i = 0; i < 8; i++) begin
			g[i] = glyph_blank;
		end
		g[7] = hex ? glyph_let_h : glyph_let_d;
		if (valid && hex) begin
			g[1] = {1'b0, v[7:4]};
			g[0] = {1'b0, v[3:0]};
		end else if (valid) begin
			// leading zeros blank, units always there
			g[0] = units[4:0];
			if (v >= 8'd10) begin
				g[1] = tens[4:0];
			end
			if (v >= 8'd100) begin
				g[2] = hundreds[4:0];
			end
		end
		for (int i = 0; i < 8; i++) begin
			all_g[5*i +: 5] = g[i];
		end
		return all_g;
	endfunction

	task automatic end_run();
		$display("errors: %0d mismatches, %0d model errors, %0d timeouts",
			mismatches, model_errors, timeouts);
		if (mismatches == 0 && model_errors == 0 && timeouts == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	task automatic count_timeout(input string what);
		$display("timeout while waiting for %s", what);
		timeouts++;
	endtask

	task automatic press_key(input int k, input int cycles);
		@(posedge sys_clk);
		key_in[k] <= 1'b0;
		repeat (cycles) @(posedge sys_clk);
		key_in[k] <= 1'b1;
		repeat (`DEBOUNCE_CYCLES + 10) @(posedge sys_clk);
	endtask

	// queue one value, then wait past its sample strobe
	task automatic load_sample(input logic [7:0] v);
		int served_before;
		int starts_before;
		int n;
		served_before = served_cnt;
		@(posedge sys_clk);
		push_value <= v;
		push_valid <= 1'b1;
		@(posedge sys_clk);
		push_valid <= 1'b0;
		newest = v;
		n = 0;
		while (served_cnt <= served_before && n < WAIT_LIMIT) begin
			@(negedge sys_clk);
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			count_timeout("the converter model to serve a sample");
		end else begin
			starts_before = start_cnt;
			n = 0;
			while (start_cnt <= starts_before && n < WAIT_LIMIT) begin
				@(negedge sys_clk);
				n++;
			end
			if (n >= WAIT_LIMIT) begin
				count_timeout("the next bus transaction");
			end
		end
	endtask

	task automatic capture_display();
		int n;
		for (int d = 0; d < 8 && timeouts == 0; d++) begin
			n = 0;
			@(negedge sys_clk);
			while (seg_choice !== ~(8'd1 << d) && n < WAIT_LIMIT) begin
				@(negedge sys_clk);
				n++;
			end
			if (n >= WAIT_LIMIT) begin
				count_timeout("a digit select");
			end else begin
				got_seg[d] = seg_number;
			end
		end
	endtask

	task automatic check_display(input int row, input logic [39:0] exp, input logic [7:0] exp_led);
		logic [7:0] want;
		capture_display();
		if (timeouts == 0) begin
			for (int d = 0; d < 8; d++) begin
				want = seg_pattern(exp[5*d +: 5]);
				if (got_seg[d] !== want) begin
					$display("mismatch seg_number digit %0d row %0d: got 0x%02h expected 0x%02h",
						d, row, got_seg[d], want);
					mismatches++;
				end
			end
			if (led !== exp_led) begin
				$display("mismatch led row %0d: got 0x%02h expected 0x%02h", row, led, exp_led);
				mismatches++;
			end
		end
	endtask

	initial begin
		int act;
		int value;
		int exp_mode;
		int exp_shown;
		sys_rst_n = 1'b0;
		key_in = '1;
		push_value = 8'h00;
		push_valid = 1'b0;
		mismatches = 0;
		timeouts = 0;
		seed = 32'h0a24_7fd5;
		newest = 8'h00;
		repeat (5) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(negedge sys_clk);
		if (seg_choice !== 8'hfe) begin
			$display("mismatch seg_choice: got 0x%02h expected 0x%02h", seg_choice, 8'hfe);
			mismatches++;
		end
		// nothing sampled yet, only the mode letter
		check_display(-1, expected_glyphs(1'b0, 1'b0, 8'h00), 8'h00);
		for (int r = 0; r < ROWS && timeouts == 0; r++) begin
			act = stim[r][0];
			value = stim[r][1];
			exp_mode = stim[r][2];
			exp_shown = stim[r][3];
			case (act)
				ACT_MODE: press_key(0, `DEBOUNCE_CYCLES + 10);
				ACT_HOLD: press_key(1, `DEBOUNCE_CYCLES + 10);
				ACT_GLITCH: press_key(0, `DEBOUNCE_CYCLES / 2);
				default: ;
			endcase
			if (value == VAL_RANDOM) begin
				value = $random(seed) & 8'hff;
			end
			if (value != VAL_NONE) begin
				load_sample(value[7:0]);
			end
			if (exp_shown == SAME) begin
				exp_shown = value;
			end
			check_display(r, expected_glyphs(1'b1, exp_mode == 1, exp_shown[7:0]), newest);
		end
		end_run();
	end

endmodule

//--- compile.f
+incdir+.
i2c_pkg.sv
panel_pkg.sv
i2c_adc_reader.sv
key_debounce.sv
display_formatter.sv
seg_scan.sv
adc_panel_top.sv
tb_i2c_adc_model.sv
tb_adc_panel.sv

//--- Bender.yml
package:
  name: adc_panel

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - i2c_pkg.sv
      - panel_pkg.sv
      - i2c_adc_reader.sv
      - key_debounce.sv
      - display_formatter.sv
      - seg_scan.sv
      - adc_panel_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_i2c_adc_model.sv
      - tb_adc_panel.sv
